// ==== design/mem_bus_defines.svh ====
// Memory bus controller parameters
// Line geometry, requester tag width and memory access pacing

`ifndef MEM_BUS_DEFINES_SVH
`define MEM_BUS_DEFINES_SVH

// Line address bits, 256 lines of 16 bytes
`define MEM_LINE_ADDR_W 8

// 32-bit beats per line
`define MEM_BEATS 4

// Requester and destination tag bits
`define MEM_SRC_W 2

// Cycles from timer start to access done
// en and wr fire on cycles 1 and 2, so keep this at 3 or more
`define MEM_ACCESS_CYCLES 4

`endif

// ==== design/mem_bus_pkg.sv ====
// Memory bus controller types
// Width typedefs shared by the design and the controller state encoding

`default_nettype none

`include "mem_bus_defines.svh"

package mem_bus_pkg;

   ////////////////////////////////////////////////////////////
   // Data widths
   ////////////////////////////////////////////////////////////

   localparam int unsigned BEAT_W = 32;

   typedef logic [`MEM_LINE_ADDR_W-1:0]   line_addr_t;
   typedef logic [BEAT_W-1:0]             beat_t;
   typedef logic [`MEM_BEATS*BEAT_W-1:0]  line_t;
   typedef logic [$clog2(`MEM_BEATS)-1:0] beat_idx_t;
   typedef logic [`MEM_SRC_W-1:0]         src_t;

   ////////////////////////////////////////////////////////////
   // Controller states
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0]
   {
      IDLE,
      WR_COLLECT,
      ACCESS,
      BUS_REQ,
      RD_SEND
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/mem_bus_ifs.sv ====
// Internal connections of the memory bus controller
// Line buffer control and the memory array port

`default_nettype none

// Slot and load control between the FSM and the line buffer
interface line_buf_if;

   logic beat_load;
   logic line_load;
   logic beat_next;
   logic beat_clear;
   logic beat_last;

   modport ctrl (output beat_load, line_load, beat_next, beat_clear,
                 input  beat_last);

   modport buffer (input  beat_load, line_load, beat_next, beat_clear,
                   output beat_last);

endinterface

// Line-wide memory port, driven from three places on the initiator side
interface mem_port_if;

   logic                   en;
   logic                   wr;
   mem_bus_pkg::line_addr_t addr;
   mem_bus_pkg::line_t      wdata;
   mem_bus_pkg::line_t      rdata;

   // Initiator views
   modport timer (output en, wr);
   modport fsm   (output addr);
   modport data  (output wdata, input rdata);

   // Array side
   modport mem (input en, wr, addr, wdata, output rdata);

endinterface

`default_nettype wire

// ==== design/mem_access_timer.sv ====
// Memory access timer
// One-hot progress shift that paces the array enable, write strobe and done

`default_nettype none

`include "mem_bus_defines.svh"

module mem_access_timer
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic start,
   input  wire logic write,
   output logic      done,
   mem_port_if.timer mp
);

   // Bit k is set k cycles after start
   logic [`MEM_ACCESS_CYCLES:1] prog_q;
   logic                        write_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         prog_q  <= '0;
         write_q <= 1'b0;
      end
      else
      begin
         if (done)
            prog_q <= '0;
         else
            prog_q <= {prog_q[`MEM_ACCESS_CYCLES-1:1], start};

         // Direction is fixed for the whole access
         if (start)
            write_q <= write;
      end
   end

   assign mp.en = prog_q[1];
   assign mp.wr = prog_q[2] && write_q;
   assign done  = prog_q[`MEM_ACCESS_CYCLES];

   // FSM only starts an access from a quiet timer
   start_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> (prog_q == '0));

endmodule

`default_nettype wire

// ==== design/line_buffer.sv ====
// Line buffer
// Assembles write beats into a line, holds read lines and presents beats in order

`default_nettype none

`include "mem_bus_defines.svh"

module line_buffer
(
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire mem_bus_pkg::beat_t wr_data,
   output mem_bus_pkg::beat_t      rsp_data,
   line_buf_if.buffer              lb,
   mem_port_if.data                mp
);

   mem_bus_pkg::line_t     line_q;
   mem_bus_pkg::beat_idx_t slot_q;

   ////////////////////////////////////////////////////////////
   // Beat slot
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         slot_q <= '0;
      else if (lb.beat_clear)
         slot_q <= '0;
      else if (lb.beat_load || lb.beat_next)
         slot_q <= slot_q + 1'b1;
   end

   assign lb.beat_last = (slot_q == mem_bus_pkg::beat_idx_t'(`MEM_BEATS - 1));

   ////////////////////////////////////////////////////////////
   // Line storage
   ////////////////////////////////////////////////////////////

   // Beat 0 sits in the low word
   always_ff @(posedge clk)
   begin
      if (lb.line_load)
         line_q <= mp.rdata;
      else if (lb.beat_load)
         line_q[slot_q*mem_bus_pkg::BEAT_W +: mem_bus_pkg::BEAT_W] <= wr_data;
   end

   assign mp.wdata = line_q;

   // Current slot goes out on the response channel
   assign rsp_data = line_q[slot_q*mem_bus_pkg::BEAT_W +: mem_bus_pkg::BEAT_W];

endmodule

`default_nettype wire

// ==== design/mem_array.sv ====
// Memory array
// 256 lines of 128 bits, line-wide write and registered read

`default_nettype none

`include "mem_bus_defines.svh"

module mem_array
(
   input  wire logic clk,
   mem_port_if.mem   mp
);

   localparam int unsigned LINES = 1 << `MEM_LINE_ADDR_W;

   mem_bus_pkg::line_t mem_q [LINES];

   // Start from a cleared memory
   initial
   begin
      for (int i = 0; i < LINES; i++)
         mem_q[i] = '0;
   end

   always @(posedge clk)
   begin
      if (mp.wr)
         mem_q[mp.addr] <= mp.wdata;

      // Read line held until the next read enable
      if (mp.en && !mp.wr)
         mp.rdata <= mem_q[mp.addr];
   end

   addr_known_a: assert property (@(posedge clk)
      mp.en |-> !$isunknown(mp.addr));

endmodule

`default_nettype wire

// ==== design/mem_ctrl_fsm.sv ====
// Memory bus controller FSM
// Sequences requests, write beats, the timed access and the read response

`default_nettype none

module mem_ctrl_fsm
(
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    req_valid,
   output logic                         req_ready,
   input  wire logic                    req_write,
   input  wire mem_bus_pkg::line_addr_t req_addr,
   input  wire mem_bus_pkg::src_t       req_src,
   input  wire logic                    wr_valid,
   output logic                         wr_ready,
   output logic                         rsp_valid,
   input  wire logic                    rsp_ready,
   output mem_bus_pkg::src_t            rsp_dest,
   output logic                         rsp_last,
   output logic                         br,
   input  wire logic                    bg,
   output logic                         timer_start,
   input  wire logic                    timer_done,
   line_buf_if.ctrl                     lb,
   mem_port_if.fsm                      mp
);

   mem_bus_pkg::ctrl_state_e state_q;
   mem_bus_pkg::ctrl_state_e state_d;
   mem_bus_pkg::line_addr_t  addr_q;
   mem_bus_pkg::src_t        src_q;
   logic                     write_q;

   ////////////////////////////////////////////////////////////
   // Request capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= mem_bus_pkg::IDLE;
         write_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (req_valid && req_ready)
            write_q <= req_write;
      end
   end

   // Address and tag are payload only
   always_ff @(posedge clk)
   begin
      if (req_valid && req_ready)
      begin
         addr_q <= req_addr;
         src_q  <= req_src;
      end
   end

   ////////////////////////////////////////////////////////////
   // Next state and buffer steering
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d       = state_q;
      timer_start   = 1'b0;
      lb.beat_load  = 1'b0;
      lb.line_load  = 1'b0;
      lb.beat_next  = 1'b0;
      lb.beat_clear = 1'b0;

      case (state_q)
         mem_bus_pkg::IDLE:
         begin
            if (req_valid)
            begin
               lb.beat_clear = 1'b1;
               if (req_write)
                  state_d = mem_bus_pkg::WR_COLLECT;
               else
               begin
                  // Reads go straight to the array
                  state_d     = mem_bus_pkg::ACCESS;
                  timer_start = 1'b1;
               end
            end
         end

         mem_bus_pkg::WR_COLLECT:
         begin
            if (wr_valid)
            begin
               lb.beat_load = 1'b1;
               if (lb.beat_last)
               begin
                  state_d     = mem_bus_pkg::ACCESS;
                  timer_start = 1'b1;
               end
            end
         end

         mem_bus_pkg::ACCESS:
         begin
            if (timer_done)
            begin
               if (write_q)
                  state_d = mem_bus_pkg::IDLE;
               else
               begin
                  lb.line_load = 1'b1;
                  state_d      = mem_bus_pkg::BUS_REQ;
               end
            end
         end

         mem_bus_pkg::BUS_REQ:
         begin
            if (bg)
               state_d = mem_bus_pkg::RD_SEND;
         end

         mem_bus_pkg::RD_SEND:
         begin
            if (rsp_ready)
            begin
               lb.beat_next = 1'b1;
               if (lb.beat_last)
                  state_d = mem_bus_pkg::IDLE;
            end
         end

         default:
         begin
            state_d = mem_bus_pkg::IDLE;
         end
      endcase
   end

   // Handshake outputs straight from the state
   assign req_ready = (state_q == mem_bus_pkg::IDLE);
   assign wr_ready  = (state_q == mem_bus_pkg::WR_COLLECT);
   assign br        = (state_q == mem_bus_pkg::BUS_REQ);
   assign rsp_valid = (state_q == mem_bus_pkg::RD_SEND);
   assign rsp_last  = rsp_valid && lb.beat_last;
   assign rsp_dest  = src_q;
   assign mp.addr   = addr_q;

   // A stalled response beat keeps its framing and tag
   rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_last) && $stable(rsp_dest));

endmodule

`default_nettype wire

// ==== design/mem_bus_top.sv ====
// Memory bus controller top level
// Request, write-beat and response channels with the arbiter pair

`default_nettype none

module mem_bus_top
(
   input  wire logic                    clk,
   input  wire logic                    rst_n,

   // Request channel
   input  wire logic                    req_valid,
   output logic                         req_ready,
   input  wire logic                    req_write,
   input  wire mem_bus_pkg::line_addr_t req_addr,
   input  wire mem_bus_pkg::src_t       req_src,

   // Write beats
   input  wire logic                    wr_valid,
   output logic                         wr_ready,
   input  wire mem_bus_pkg::beat_t      wr_data,

   // Read response
   output logic                         rsp_valid,
   input  wire logic                    rsp_ready,
   output mem_bus_pkg::beat_t           rsp_data,
   output mem_bus_pkg::src_t            rsp_dest,
   output logic                         rsp_last,

   // Arbiter
   output logic                         br,
   input  wire logic                    bg
);

   logic timer_start;
   logic timer_done;

   line_buf_if lb_if ();
   mem_port_if mp_if ();

   mem_ctrl_fsm u_fsm
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_write   (req_write),
      .req_addr    (req_addr),
      .req_src     (req_src),
      .wr_valid    (wr_valid),
      .wr_ready    (wr_ready),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp_dest    (rsp_dest),
      .rsp_last    (rsp_last),
      .br          (br),
      .bg          (bg),
      .timer_start (timer_start),
      .timer_done  (timer_done),
      .lb          (lb_if.ctrl),
      .mp          (mp_if.fsm)
   );

   // Writes start from the beat phase, reads from idle
   mem_access_timer u_timer
   (
      .clk   (clk),
      .rst_n (rst_n),
      .start (timer_start),
      .write (wr_ready),
      .done  (timer_done),
      .mp    (mp_if.timer)
   );

   line_buffer u_line_buf
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_data  (wr_data),
      .rsp_data (rsp_data),
      .lb       (lb_if.buffer),
      .mp       (mp_if.data)
   );

   mem_array u_mem
   (
      .clk (clk),
      .mp  (mp_if.mem)
   );

endmodule

`default_nettype wire

// ==== tb/mem_bus_checker.sv ====
// Memory bus controller checker
// Compares read beats, tags and framing, and watches the handshake rules

`default_nettype none

`include "mem_bus_defines.svh"

module mem_bus_checker
(
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               req_valid,
   input  wire logic               req_ready,
   input  wire logic               req_write,
   input  wire logic               wr_valid,
   input  wire logic               wr_ready,
   input  wire logic               br,
   input  wire logic               bg,
   input  wire logic               rsp_valid,
   input  wire logic               rsp_ready,
   input  wire mem_bus_pkg::beat_t rsp_data,
   input  wire mem_bus_pkg::src_t  rsp_dest,
   input  wire logic               rsp_last,
   output int                      errors,
   output int                      beats
);

   timeunit 1ns;
   timeprecision 1ps;

   // Expected beats, queued by the testbench before each read
   mem_bus_pkg::beat_t exp_data_q [$];
   mem_bus_pkg::src_t  exp_dest_q [$];
   logic               exp_last_q [$];

   logic               prev_stall;
   mem_bus_pkg::beat_t prev_data;
   mem_bus_pkg::src_t  prev_dest;
   logic               prev_last;
   logic               prev_br;
   logic               prev_bg;
   logic               granted;
   logic               busy;
   int                 wr_left;
   int                 done_cnt;

   task automatic push_expect(input mem_bus_pkg::beat_t d, input mem_bus_pkg::src_t s,
                              input logic l);
      exp_data_q.push_back(d);
      exp_dest_q.push_back(s);
      exp_last_q.push_back(l);
   endtask

   task automatic report_value(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
   endtask

   task automatic report_rule(input string msg);
      $display("Protocol error at %0t ns: %s", $time, msg);
   endtask

   ////////////////////////////////////////////////////////////
   // Per-cycle checks
   ////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin : watch
      int                 n;
      mem_bus_pkg::beat_t d;
      mem_bus_pkg::src_t  s;
      logic               l;

      n = 0;
      if (!rst_n)
      begin
         errors     <= 0;
         beats      <= 0;
         busy       <= 1'b0;
         granted    <= 1'b0;
         prev_stall <= 1'b0;
         prev_br    <= 1'b0;
         prev_bg    <= 1'b0;
         wr_left    <= 0;
         done_cnt   <= 0;
      end
      else
      begin
         // Request channel closed until the current request ends, open otherwise
         if (busy == req_ready)
         begin
            report_rule("req_ready does not follow the request in progress");
            n++;
         end
         if (req_valid && req_ready)
         begin
            busy <= 1'b1;
            if (req_write)
               wr_left <= `MEM_BEATS;
         end

         // Beat channel open only while a write line is collecting
         if (wr_ready != (wr_left > 0))
         begin
            report_rule("wr_ready is out of step with the write beats");
            n++;
         end

         // A write ends a fixed number of cycles after its last beat
         if (wr_valid && wr_ready && wr_left > 0)
         begin
            wr_left <= wr_left - 1;
            if (wr_left == 1)
               done_cnt <= `MEM_ACCESS_CYCLES;
         end
         if (done_cnt > 0)
         begin
            done_cnt <= done_cnt - 1;
            if (done_cnt == 1)
               busy <= 1'b0;
         end

         // Arbiter pair
         if (prev_br && !prev_bg && !br)
         begin
            report_rule("br dropped before bg was given");
            n++;
         end
         if (br && bg)
            granted <= 1'b1;
         if (rsp_valid && !granted)
         begin
            report_rule("rsp_valid came up before the bus was granted");
            n++;
         end

         // Stalled beat must hold
         if (prev_stall && (!rsp_valid || rsp_data !== prev_data ||
                            rsp_dest !== prev_dest || rsp_last !== prev_last))
         begin
            report_rule("response beat changed while rsp_ready was low");
            n++;
         end

         if (rsp_valid && rsp_ready)
         begin
            if (exp_data_q.size() == 0)
            begin
               report_rule("response beat arrived with no read outstanding");
               n++;
            end
            else
            begin
               d = exp_data_q.pop_front();
               s = exp_dest_q.pop_front();
               l = exp_last_q.pop_front();
               if (rsp_data !== d)
               begin
                  report_value($sformatf("rsp_data %h, expected %h", rsp_data, d));
                  n++;
               end
               if (rsp_dest !== s)
               begin
                  report_value($sformatf("rsp_dest %0d, expected %0d", rsp_dest, s));
                  n++;
               end
               if (rsp_last !== l)
               begin
                  report_value($sformatf("rsp_last %b, expected %b", rsp_last, l));
                  n++;
               end
            end
            beats <= beats + 1;
            if (rsp_last)
            begin
               granted <= 1'b0;
               busy    <= 1'b0;
            end
         end

         prev_stall <= rsp_valid && !rsp_ready;
         prev_data  <= rsp_data;
         prev_dest  <= rsp_dest;
         prev_last  <= rsp_last;
         prev_br    <= br;
         prev_bg    <= bg;
         errors     <= errors + n;
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_mem_bus.sv ====
// Memory bus controller testbench
// Drives reads and writes, keeps a shadow memory and bounds the run time

`default_nettype none

`include "mem_bus_defines.svh"

module tb_mem_bus;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD      = 40;
   localparam int LINES           = 1 << `MEM_LINE_ADDR_W;
   localparam int MIX_OPS         = 24;
   // Reads and writes over all tests
   localparam int N_TRANS         = 20 + MIX_OPS;
   localparam int WATCHDOG_CYCLES = N_TRANS * 100;

   logic                    clk;
   logic                    rst_n;
   logic                    req_valid;
   logic                    req_ready;
   logic                    req_write;
   mem_bus_pkg::line_addr_t req_addr;
   mem_bus_pkg::src_t       req_src;
   logic                    wr_valid;
   logic                    wr_ready;
   mem_bus_pkg::beat_t      wr_data;
   logic                    rsp_valid;
   logic                    rsp_ready;
   mem_bus_pkg::beat_t      rsp_data;
   mem_bus_pkg::src_t       rsp_dest;
   logic                    rsp_last;
   logic                    br;
   logic                    bg;
   int                      errors;
   int                      beats;
   int                      seed = 32'h3025;
   int                      errors_before;
   logic                    stall_on;
   mem_bus_pkg::line_t      shadow [LINES];

   mem_bus_top DUT
   (
      .clk (clk), .rst_n (rst_n),
      .req_valid (req_valid), .req_ready (req_ready), .req_write (req_write),
      .req_addr (req_addr), .req_src (req_src),
      .wr_valid (wr_valid), .wr_ready (wr_ready), .wr_data (wr_data),
      .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_data (rsp_data),
      .rsp_dest (rsp_dest), .rsp_last (rsp_last),
      .br (br), .bg (bg)
   );

   mem_bus_checker chk
   (
      .clk (clk), .rst_n (rst_n),
      .req_valid (req_valid), .req_ready (req_ready), .req_write (req_write),
      .wr_valid (wr_valid), .wr_ready (wr_ready), .br (br), .bg (bg),
      .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_data (rsp_data),
      .rsp_dest (rsp_dest), .rsp_last (rsp_last),
      .errors (errors), .beats (beats)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Response back-pressure, ready about two cycles in three when stalling
   always @(posedge clk)
   begin
      if (stall_on)
         rsp_ready <= ($random(seed) % 3) != 0;
      else
         rsp_ready <= 1'b1;
   end

   // Beat 0 is the low word of a line
   function automatic mem_bus_pkg::beat_t expected_beat(input mem_bus_pkg::line_addr_t a,
                                                        input int i);
      return shadow[a][i*32 +: 32];
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus transactions
   ////////////////////////////////////////////////////////////

   task automatic write_line(input mem_bus_pkg::line_addr_t a, input mem_bus_pkg::src_t s,
                             input mem_bus_pkg::line_t d);
      req_valid <= 1'b1;
      req_write <= 1'b1;
      req_addr  <= a;
      req_src   <= s;
      do @(posedge clk); while (!req_ready);
      req_valid <= 1'b0;
      for (int i = 0; i < `MEM_BEATS; i++)
      begin
         wr_valid <= 1'b1;
         wr_data  <= d[i*32 +: 32];
         do @(posedge clk); while (!wr_ready);
      end
      wr_valid  <= 1'b0;
      shadow[a] = d;
   endtask

   task automatic read_line(input mem_bus_pkg::line_addr_t a, input mem_bus_pkg::src_t s,
                            input int bg_delay);
      for (int i = 0; i < `MEM_BEATS; i++)
         chk.push_expect(expected_beat(a, i), s, i == `MEM_BEATS - 1);
      req_valid <= 1'b1;
      req_write <= 1'b0;
      req_addr  <= a;
      req_src   <= s;
      do @(posedge clk); while (!req_ready);
      req_valid <= 1'b0;
      // Arbiter answers after a chosen delay
      do @(posedge clk); while (!br);
      repeat (bg_delay) @(posedge clk);
      bg <= 1'b1;
      @(posedge clk);
      bg <= 1'b0;
      do @(posedge clk); while (!(rsp_valid && rsp_ready && rsp_last));
   endtask

   task automatic end_test(input int num, input string name);
      @(posedge clk);
      $display("Test %0d (%s) done with %0d errors", num, name, errors - errors_before);
      errors_before = errors;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin : main
      mem_bus_pkg::line_t      d;
      mem_bus_pkg::line_addr_t a;

      rst_n     = 1'b0;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr  = '0;
      req_src   = '0;
      wr_valid  = 1'b0;
      wr_data   = '0;
      rsp_ready = 1'b1;
      bg        = 1'b0;
      stall_on  = 1'b0;
      errors_before = 0;
      for (int i = 0; i < LINES; i++)
         shadow[i] = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      read_line(8'hA5, 2'd0, 0);
      read_line(8'h5A, 2'd1, 2);
      end_test(1, "unwritten lines read as zero");

      repeat (3)
      begin
         a = mem_bus_pkg::line_addr_t'($random(seed));
         d = {$random(seed), $random(seed), $random(seed), $random(seed)};
         write_line(a, 2'd0, d);
         read_line(a, 2'd2, 1);
      end
      end_test(2, "write then read back");

      for (int s = 0; s < 4; s++)
         read_line(a, mem_bus_pkg::src_t'(s), 0);
      end_test(3, "destination tag follows requester");

      repeat (4)
         read_line(a, mem_bus_pkg::src_t'($random(seed)), $random(seed) & 32'hF);
      end_test(4, "delayed bus grant");

      stall_on <= 1'b1;
      repeat (4)
         read_line(a, mem_bus_pkg::src_t'($random(seed)), 0);
      stall_on <= 1'b0;
      end_test(5, "response back-pressure");

      // Few lines, so reads often hit earlier writes
      stall_on <= 1'b1;
      repeat (MIX_OPS)
      begin
         a = mem_bus_pkg::line_addr_t'($random(seed) & 32'hF);
         if ($random(seed) & 1)
         begin
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            write_line(a, mem_bus_pkg::src_t'($random(seed)), d);
         end
         else
            read_line(a, mem_bus_pkg::src_t'($random(seed)), $random(seed) & 32'h7);
      end
      // Let a trailing write finish its access
      while (!req_ready)
         @(posedge clk);
      stall_on <= 1'b0;
      end_test(6, "random mix against shadow memory");

      $display("Summary: %0d beats checked, %0d errors", beats, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/mem_bus_pkg.sv
design/mem_bus_ifs.sv
design/mem_access_timer.sv
design/line_buffer.sv
design/mem_array.sv
design/mem_ctrl_fsm.sv
design/mem_bus_top.sv
tb/mem_bus_checker.sv
tb/tb_mem_bus.sv

// ==== Bender.yml ====
package:
  name: mem_bus

sources:
  - include_dirs:
      - design
    files:
      - design/mem_bus_pkg.sv
      - design/mem_bus_ifs.sv
      - design/mem_access_timer.sv
      - design/line_buffer.sv
      - design/mem_array.sv
      - design/mem_ctrl_fsm.sv
      - design/mem_bus_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/mem_bus_checker.sv
      - tb/tb_mem_bus.sv
